/* design/cacc_params.svh */
// size and register map macros for the convolution accumulator, included by every design file
`ifndef CACC_PARAMS_SVH
`define CACC_PARAMS_SVH

// an atom carries this many lanes of partial sums
`define CACC_LANES          4
// signed width of one partial sum coming from the MAC array
`define CACC_MAC_W          16
// signed width of one running sum kept in the accumulation buffer
`define CACC_PSUM_W         24
// width of one delivered lane, int8 results get sign-extended up to it
`define CACC_OUT_W          16

// one buffer entry per atom of a stripe, so 16 atoms at most
`define CACC_ABUF_AWIDTH    4
`define CACC_ABUF_DEPTH     (1 << `CACC_ABUF_AWIDTH)

// Wishbone bus is word addressed
`define CACC_WB_AW          8
`define CACC_WB_DW          32

// register map in words
`define CACC_REG_OP_EN      8'h00
`define CACC_REG_CFG        8'h01
`define CACC_REG_STATUS     8'h02
// the buffer window starts here, one word per lane of each entry
`define CACC_ABUF_WIN_BASE  8'h40

`endif

/* design/cacc_pkg.sv */
// types shared across the accumulator blocks, imported in module bodies or named in port lists
`include "cacc_params.svh"

package cacc_pkg;

  // processing precision selects the saturation range on delivery
  typedef enum logic {
    PREC_INT8  = 1'b0,
    PREC_INT16 = 1'b1
  } cacc_precision_e;

  // position flags that travel with each atom, packed in the order of mac_pd
  typedef struct packed {
    logic layer_end;
    logic channel_end;
    logic stripe_end;
    logic stripe_st;
  } cacc_atom_flags_t;

  // one atom as handed from the control block to the datapath
  typedef struct packed {
    logic [`CACC_ABUF_AWIDTH-1:0]       addr;
    // set on the first channel group of a stripe, when no stored sum exists yet
    logic                               first;
    cacc_atom_flags_t                   flags;
    logic [`CACC_LANES*`CACC_MAC_W-1:0] data;
  } cacc_ctrl_t;

  // owner of the buffer read data in the current cycle
  typedef enum logic {
    ARB_ASM,
    ARB_BUS
  } cacc_arb_state_e;

  // Wishbone slave sequencing
  typedef enum logic [1:0] {
    WB_IDLE,
    WB_BUF_WAIT,
    WB_ACK
  } cacc_wb_state_e;

endpackage

/* design/cacc_abuf_if.sv */
// one access port of the accumulation buffer, connecting a requester block to the buffer
`timescale 1ns/1ns
`include "cacc_params.svh"

interface cacc_abuf_if;

  logic                                req;
  logic                                we;
  logic [`CACC_ABUF_AWIDTH-1:0]        addr;
  // all lanes of one entry move together
  logic [`CACC_LANES*`CACC_PSUM_W-1:0] wdata;
  // registered read data, valid the cycle after a granted read
  logic [`CACC_LANES*`CACC_PSUM_W-1:0] rdata;

  modport requester (output req, output we, output addr, output wdata, input rdata);
  modport server    (input req, input we, input addr, input wdata, output rdata);

endinterface

/* design/cacc_assembly_ctrl.sv */
// assembly control for the accumulator, turns MAC atoms into buffer reads and datapath control
`timescale 1ns/1ns
`include "cacc_params.svh"

module cacc_assembly_ctrl (
  input  logic                               nvdla_core_clk,
  input  logic                               reset,
  input  logic                               mac_pvld,
  input  cacc_pkg::cacc_atom_flags_t         mac_flags,
  input  logic [`CACC_LANES*`CACC_MAC_W-1:0] mac_data,
  input  logic                               op_en,
  input  logic                               layer_done,
  output logic                               wait_for_op_en,
  cacc_abuf_if.requester                     abuf_rd,
  output logic                               ctrl_valid,
  output cacc_pkg::cacc_ctrl_t               ctrl
);
  import cacc_pkg::*;

  logic                               accu_valid;
  cacc_atom_flags_t                   accu_flags;
  logic [`CACC_LANES*`CACC_MAC_W-1:0] accu_data;
  logic [`CACC_ABUF_AWIDTH-1:0]       accu_cnt;
  logic                               accu_channel_st;
  logic                               layer_st;

  //////////////////////////////////////////////////////////////////////
  // layer start
  //////////////////////////////////////////////////////////////////////

  // a finished layer parks the block until software enables the next one
  always_ff @(posedge nvdla_core_clk) begin
    if (reset) begin
      wait_for_op_en <= 1'b1;
    end else if (layer_done) begin
      wait_for_op_en <= 1'b1;
    end else if (op_en) begin
      wait_for_op_en <= 1'b0;
    end
  end

  // the new layer begins in the cycle op-enable meets the waiting state
  assign layer_st = wait_for_op_en & op_en;

  //////////////////////////////////////////////////////////////////////
  // input stage
  //////////////////////////////////////////////////////////////////////

  // atoms seen while waiting for op-enable are dropped here
  always_ff @(posedge nvdla_core_clk) begin
    if (reset) begin
      accu_valid <= 1'b0;
    end else begin
      accu_valid <= mac_pvld & ~wait_for_op_en;
    end
  end

  always_ff @(posedge nvdla_core_clk) begin
    if (mac_pvld) begin
      accu_flags <= mac_flags;
      accu_data  <= mac_data;
    end
  end

  // the address walks the stripe one entry per atom and wraps at stripe end
  // channel start holds over the whole stripe and is refreshed from channel end,
  // so the stripe after a channel end starts a fresh sum
  always_ff @(posedge nvdla_core_clk) begin
    if (reset) begin
      accu_cnt        <= '0;
      accu_channel_st <= 1'b1;
    end else if (layer_st) begin
      accu_cnt        <= '0;
      accu_channel_st <= 1'b1;
    end else if (accu_valid) begin
      if (accu_flags.stripe_end) begin
        accu_cnt        <= '0;
        accu_channel_st <= accu_flags.channel_end;
      end else begin
        accu_cnt <= accu_cnt + 1'b1;
      end
    end
  end

  // a channel start needs no stored sum, every other atom fetches its entry
  assign abuf_rd.req   = accu_valid & ~accu_channel_st;
  assign abuf_rd.we    = 1'b0;
  assign abuf_rd.addr  = accu_cnt;
  assign abuf_rd.wdata = '0;

  // control leaves together with the read, so the data lines up in the datapath
  always_ff @(posedge nvdla_core_clk) begin
    if (reset) begin
      ctrl_valid <= 1'b0;
    end else begin
      ctrl_valid <= accu_valid;
    end
  end

  always_ff @(posedge nvdla_core_clk) begin
    if (accu_valid) begin
      ctrl.addr  <= accu_cnt;
      ctrl.first <= accu_channel_st;
      ctrl.flags <= accu_flags;
      ctrl.data  <= accu_data;
    end
  end

endmodule

/* design/cacc_assembly_dp.sv */
// assembly datapath, accumulates atoms into the buffer and delivers truncated saturated sums
`timescale 1ns/1ns
`include "cacc_params.svh"

module cacc_assembly_dp (
  input  logic                                nvdla_core_clk,
  input  logic                                reset,
  input  logic                                ctrl_valid,
  input  cacc_pkg::cacc_ctrl_t                ctrl,
  input  logic [`CACC_LANES*`CACC_PSUM_W-1:0] abuf_rd_data,
  cacc_abuf_if.requester                      abuf_wr,
  input  logic [4:0]                          cfg_truncate,
  input  cacc_pkg::cacc_precision_e           cfg_precision,
  output logic                                out_valid,
  output logic [`CACC_LANES*`CACC_OUT_W-1:0]  out_data,
  output logic                                out_layer_end,
  output logic                                layer_done
);
  import cacc_pkg::*;

  localparam int LANES = `CACC_LANES;
  localparam int MW    = `CACC_MAC_W;
  localparam int PW    = `CACC_PSUM_W;
  localparam int OW    = `CACC_OUT_W;

  logic [LANES*PW-1:0] sum_all;
  logic [LANES*PW-1:0] dlv_sum;
  logic                dlv_valid;
  logic                dlv_layer_end;
  logic [LANES*OW-1:0] sat_all;

  // arithmetic shift then clamp into the precision range
  function automatic logic [OW-1:0] trunc_sat(input logic signed [PW-1:0] sum,
                                               input logic [4:0]           shift,
                                               input logic                 is_int8);
    logic signed [PW-1:0] val;
    logic signed [PW-1:0] max_v;
    logic signed [PW-1:0] min_v;
    val   = sum >>> shift;
    max_v = is_int8 ? PW'(127) : PW'(32767);
    min_v = is_int8 ? PW'(-128) : PW'(-32768);
    if (val > max_v) begin
      val = max_v;
    end else if (val < min_v) begin
      val = min_v;
    end
    // int8 results keep their sign bits in the upper byte
    return OW'(val);
  endfunction

  //////////////////////////////////////////////////////////////////////
  // accumulate and write back
  //////////////////////////////////////////////////////////////////////

  // the first channel group starts from zero instead of the stale entry
  always_comb begin
    for (int i = 0; i < LANES; i++) begin
      sum_all[i*PW +: PW] = (ctrl.first ? '0 : abuf_rd_data[i*PW +: PW])
                          + PW'(signed'(ctrl.data[i*MW +: MW]));
    end
  end

  // every atom writes its sum back, also on channel end
  assign abuf_wr.req   = ctrl_valid;
  assign abuf_wr.we    = 1'b1;
  assign abuf_wr.addr  = ctrl.addr;
  assign abuf_wr.wdata = sum_all;

  //////////////////////////////////////////////////////////////////////
  // delivery
  //////////////////////////////////////////////////////////////////////

  // only channel-end sums move on toward the output
  always_ff @(posedge nvdla_core_clk) begin
    if (reset) begin
      dlv_valid <= 1'b0;
    end else begin
      dlv_valid <= ctrl_valid & ctrl.flags.channel_end;
    end
  end

  always_ff @(posedge nvdla_core_clk) begin
    if (ctrl_valid & ctrl.flags.channel_end) begin
      dlv_sum       <= sum_all;
      dlv_layer_end <= ctrl.flags.layer_end;
    end
  end

  always_comb begin
    for (int i = 0; i < LANES; i++) begin
      sat_all[i*OW +: OW] = trunc_sat(dlv_sum[i*PW +: PW], cfg_truncate,
                                      cfg_precision == PREC_INT8);
    end
  end

  always_ff @(posedge nvdla_core_clk) begin
    if (reset) begin
      out_valid     <= 1'b0;
      out_layer_end <= 1'b0;
    end else begin
      out_valid     <= dlv_valid;
      out_layer_end <= dlv_valid & dlv_layer_end;
    end
  end

  always_ff @(posedge nvdla_core_clk) begin
    if (dlv_valid) begin
      out_data <= sat_all;
    end
  end

  // the layer is finished once its last sum leaves
  assign layer_done = out_valid & out_layer_end;

endmodule

/* design/cacc_abuf.sv */
// accumulation buffer, one write port for assembly and one arbitrated read port
`timescale 1ns/1ns
`include "cacc_params.svh"

module cacc_abuf (
  input  logic                         nvdla_core_clk,
  input  logic                         reset,
  cacc_abuf_if.server                  asm_rd,
  cacc_abuf_if.server                  asm_wr,
  input  logic                         bus_req,
  input  logic [`CACC_ABUF_AWIDTH-1:0] bus_addr,
  output logic                         bus_gnt
);
  import cacc_pkg::*;

  logic [`CACC_LANES*`CACC_PSUM_W-1:0] mem [`CACC_ABUF_DEPTH];
  logic [`CACC_LANES*`CACC_PSUM_W-1:0] rd_data;
  logic [`CACC_ABUF_AWIDTH-1:0]        rd_addr;
  logic                                asm_rd_en;
  logic                                wr_en;
  logic                                rd_en;
  cacc_arb_state_e                     arb_state;

  assign asm_rd_en = asm_rd.req & ~asm_rd.we;
  assign wr_en     = asm_wr.req & asm_wr.we;

  // assembly always wins the read port
  // the bus gets it in a free cycle, but not twice in a row, so its data
  // has a cycle to be picked up before the next bus read
  assign bus_gnt = bus_req & ~asm_rd_en & (arb_state == ARB_ASM);
  assign rd_en   = asm_rd_en | bus_gnt;
  assign rd_addr = asm_rd_en ? asm_rd.addr : bus_addr;

  always_ff @(posedge nvdla_core_clk) begin
    if (reset) begin
      arb_state <= ARB_ASM;
    end else if (bus_gnt) begin
      arb_state <= ARB_BUS;
    end else begin
      arb_state <= ARB_ASM;
    end
  end

  always_ff @(posedge nvdla_core_clk) begin
    if (wr_en) begin
      mem[asm_wr.addr] <= asm_wr.wdata;
    end
  end

  // write-first, a one-atom stripe reads the sum written on the same edge
  always_ff @(posedge nvdla_core_clk) begin
    if (rd_en) begin
      if (wr_en && (asm_wr.addr == rd_addr)) begin
        rd_data <= asm_wr.wdata;
      end else begin
        rd_data <= mem[rd_addr];
      end
    end
  end

  // both ports see the same registered read data
  assign asm_rd.rdata = rd_data;
  assign asm_wr.rdata = rd_data;

endmodule

/* design/cacc_regs.sv */
// Wishbone classic slave with layer configuration, op-enable, status and a buffer read window
`timescale 1ns/1ns
`include "cacc_params.svh"

module cacc_regs (
  input  logic                                nvdla_core_clk,
  input  logic                                reset,
  input  logic                                wb_cyc,
  input  logic                                wb_stb,
  input  logic                                wb_we,
  input  logic [`CACC_WB_AW-1:0]              wb_adr,
  input  logic [`CACC_WB_DW-1:0]              wb_dat_w,
  output logic [`CACC_WB_DW-1:0]              wb_dat_r,
  output logic                                wb_ack,
  output logic                                op_en,
  output logic [4:0]                          cfg_truncate,
  output cacc_pkg::cacc_precision_e           cfg_precision,
  input  logic                                layer_done,
  input  logic                                wait_for_op_en,
  output logic                                bus_req,
  output logic [`CACC_ABUF_AWIDTH-1:0]        bus_addr,
  input  logic                                bus_gnt,
  input  logic [`CACC_LANES*`CACC_PSUM_W-1:0] abuf_rd_data
);
  import cacc_pkg::*;

  localparam int PW = `CACC_PSUM_W;
  localparam int DW = `CACC_WB_DW;
  localparam int LW = $clog2(`CACC_LANES);
  localparam logic [`CACC_WB_AW-1:0] WIN_END =
    `CACC_ABUF_WIN_BASE + `CACC_LANES * `CACC_ABUF_DEPTH;

  cacc_wb_state_e       state;
  logic                 access;
  logic                 win_hit;
  logic [`CACC_WB_AW-1:0] win_off;
  logic [LW-1:0]        win_lane;
  logic                 win_rd;
  logic                 done;
  logic [DW-1:0]        reg_rdata;
  logic signed [PW-1:0] lane_sum;

  // a new bus cycle is only taken from idle
  assign access  = (state == WB_IDLE) & wb_cyc & wb_stb;
  assign win_off = wb_adr - `CACC_ABUF_WIN_BASE;
  assign win_hit = (wb_adr >= `CACC_ABUF_WIN_BASE) && (wb_adr < WIN_END);

  //////////////////////////////////////////////////////////////////////
  // bus handshake
  //////////////////////////////////////////////////////////////////////

  // registers ack next cycle, window reads wait for the buffer grant first
  always_ff @(posedge nvdla_core_clk) begin
    if (reset) begin
      state <= WB_IDLE;
    end else begin
      case (state)
        WB_IDLE: begin
          if (wb_cyc & wb_stb) begin
            state <= (win_hit & ~wb_we) ? WB_BUF_WAIT : WB_ACK;
          end
        end
        WB_BUF_WAIT: begin
          if (bus_gnt) begin
            state <= WB_ACK;
          end
        end
        default: begin
          state <= WB_IDLE;
        end
      endcase
    end
  end

  assign wb_ack  = (state == WB_ACK);
  assign bus_req = (state == WB_BUF_WAIT);

  // window address splits into entry and lane, lane in the low bits
  always_ff @(posedge nvdla_core_clk) begin
    if (access) begin
      win_rd   <= win_hit & ~wb_we;
      bus_addr <= win_off[LW +: `CACC_ABUF_AWIDTH];
      win_lane <= win_off[LW-1:0];
      case (wb_adr)
        `CACC_REG_CFG:    reg_rdata <= {{(DW-9){1'b0}}, cfg_precision, 3'b000, cfg_truncate};
        `CACC_REG_STATUS: reg_rdata <= {{(DW-2){1'b0}}, wait_for_op_en, done};
        default:          reg_rdata <= '0;
      endcase
    end
  end

  // buffer data arrives with the ack cycle, so the lane is picked live
  assign lane_sum = abuf_rd_data[win_lane*PW +: PW];
  assign wb_dat_r = win_rd ? {{(DW-PW){lane_sum[PW-1]}}, lane_sum} : reg_rdata;

  //////////////////////////////////////////////////////////////////////
  // configuration and status
  //////////////////////////////////////////////////////////////////////

  // configuration only changes between layers
  // done sets after the last output and is cleared by the next start
  always_ff @(posedge nvdla_core_clk) begin
    if (reset) begin
      op_en         <= 1'b0;
      cfg_truncate  <= '0;
      cfg_precision <= PREC_INT8;
      done          <= 1'b0;
    end else begin
      op_en <= access & wb_we & (wb_adr == `CACC_REG_OP_EN) & wb_dat_w[0];
      if (access & wb_we & (wb_adr == `CACC_REG_CFG) & wait_for_op_en) begin
        cfg_truncate  <= wb_dat_w[4:0];
        cfg_precision <= cacc_precision_e'(wb_dat_w[8]);
      end
      if (layer_done) begin
        done <= 1'b1;
      end else if (op_en) begin
        done <= 1'b0;
      end
    end
  end

endmodule

/* design/cacc_top.sv */
// top of the accumulator assembly stage, MAC atoms in, delivered sums and Wishbone on plain ports
`timescale 1ns/1ns
`include "cacc_params.svh"

module cacc_top (
  input  logic                               nvdla_core_clk,
  input  logic                               reset,
  input  logic                               mac_pvld,
  // stripe start, stripe end, channel end and layer end from bit 0 up
  input  logic [3:0]                         mac_pd,
  input  logic [`CACC_LANES*`CACC_MAC_W-1:0] mac_data,
  input  logic                               wb_cyc,
  input  logic                               wb_stb,
  input  logic                               wb_we,
  input  logic [`CACC_WB_AW-1:0]             wb_adr,
  input  logic [`CACC_WB_DW-1:0]             wb_dat_w,
  output logic [`CACC_WB_DW-1:0]             wb_dat_r,
  output logic                               wb_ack,
  output logic                               out_valid,
  output logic [`CACC_LANES*`CACC_OUT_W-1:0] out_data,
  output logic                               out_layer_end
);
  import cacc_pkg::*;

  cacc_atom_flags_t             mac_flags;
  logic                         op_en;
  logic [4:0]                   cfg_truncate;
  cacc_precision_e              cfg_precision;
  logic                         layer_done;
  logic                         wait_for_op_en;
  logic                         ctrl_valid;
  cacc_ctrl_t                   ctrl;
  logic                         bus_req;
  logic [`CACC_ABUF_AWIDTH-1:0] bus_addr;
  logic                         bus_gnt;

  // assembly read and write ports of the buffer
  cacc_abuf_if asm_rd ();
  cacc_abuf_if asm_wr ();

  assign mac_flags = mac_pd;

  cacc_assembly_ctrl u_ctrl (
    .nvdla_core_clk (nvdla_core_clk),
    .reset          (reset),
    .mac_pvld       (mac_pvld),
    .mac_flags      (mac_flags),
    .mac_data       (mac_data),
    .op_en          (op_en),
    .layer_done     (layer_done),
    .wait_for_op_en (wait_for_op_en),
    .abuf_rd        (asm_rd.requester),
    .ctrl_valid     (ctrl_valid),
    .ctrl           (ctrl)
  );

  cacc_assembly_dp u_dp (
    .nvdla_core_clk (nvdla_core_clk),
    .reset          (reset),
    .ctrl_valid     (ctrl_valid),
    .ctrl           (ctrl),
    .abuf_rd_data   (asm_rd.rdata),
    .abuf_wr        (asm_wr.requester),
    .cfg_truncate   (cfg_truncate),
    .cfg_precision  (cfg_precision),
    .out_valid      (out_valid),
    .out_data       (out_data),
    .out_layer_end  (out_layer_end),
    .layer_done     (layer_done)
  );

  cacc_abuf u_abuf (
    .nvdla_core_clk (nvdla_core_clk),
    .reset          (reset),
    .asm_rd         (asm_rd.server),
    .asm_wr         (asm_wr.server),
    .bus_req        (bus_req),
    .bus_addr       (bus_addr),
    .bus_gnt        (bus_gnt)
  );

  // the window shares the read data register with assembly reads
  cacc_regs u_regs (
    .nvdla_core_clk (nvdla_core_clk),
    .reset          (reset),
    .wb_cyc         (wb_cyc),
    .wb_stb         (wb_stb),
    .wb_we          (wb_we),
    .wb_adr         (wb_adr),
    .wb_dat_w       (wb_dat_w),
    .wb_dat_r       (wb_dat_r),
    .wb_ack         (wb_ack),
    .op_en          (op_en),
    .cfg_truncate   (cfg_truncate),
    .cfg_precision  (cfg_precision),
    .layer_done     (layer_done),
    .wait_for_op_en (wait_for_op_en),
    .bus_req        (bus_req),
    .bus_addr       (bus_addr),
    .bus_gnt        (bus_gnt),
    .abuf_rd_data   (asm_rd.rdata)
  );

endmodule

/* dv/cacc_tb.sv */
// testbench for the accumulator top, replays the testdata file and checks outputs and readbacks
`timescale 1ns/1ns
`include "cacc_params.svh"

module cacc_tb;

  logic        nvdla_core_clk;
  logic        reset;
  logic        mac_pvld;
  logic [3:0]  mac_pd;
  logic [63:0] mac_data;
  logic        wb_cyc;
  logic        wb_stb;
  logic        wb_we;
  logic [7:0]  wb_adr;
  logic [31:0] wb_dat_w;
  logic [31:0] wb_dat_r;
  logic        wb_ack;
  logic        out_valid;
  logic [63:0] out_data;
  logic        out_layer_end;

  // expected deliveries, compared in arrival order
  logic [63:0] exp_data_q[$];
  logic        exp_le_q[$];
  string       exp_name_q[$];
  string       lines[$];
  int          nrec;
  int          mismatch_cnt;
  int          other_cnt;
  // ack level at the previous falling edge
  logic        ack_seen;

  cacc_top dut (
    .nvdla_core_clk (nvdla_core_clk),
    .reset          (reset),
    .mac_pvld       (mac_pvld),
    .mac_pd         (mac_pd),
    .mac_data       (mac_data),
    .wb_cyc         (wb_cyc),
    .wb_stb         (wb_stb),
    .wb_we          (wb_we),
    .wb_adr         (wb_adr),
    .wb_dat_w       (wb_dat_w),
    .wb_dat_r       (wb_dat_r),
    .wb_ack         (wb_ack),
    .out_valid      (out_valid),
    .out_data       (out_data),
    .out_layer_end  (out_layer_end)
  );

  always #5 nvdla_core_clk = ~nvdla_core_clk;

  //////////////////////////////////////////////////////////////////////
  // drivers
  //////////////////////////////////////////////////////////////////////

  // every drive happens 1 ns after the rising edge, an atom lasts one cycle
  task automatic step();
    @(posedge nvdla_core_clk);
    #1;
    mac_pvld = 1'b0;
  endtask

  // ack is looked at on the falling edge where it is stable
  task automatic wait_ack(output logic [31:0] data);
    @(negedge nvdla_core_clk);
    while (!wb_ack) begin
      @(negedge nvdla_core_clk);
    end
    data = wb_dat_r;
    step();
    wb_cyc = 1'b0;
    wb_stb = 1'b0;
    wb_we  = 1'b0;
  endtask

  task automatic bus_write(input logic [7:0] adr, input logic [31:0] dat);
    logic [31:0] unused;
    step();
    wb_cyc   = 1'b1;
    wb_stb   = 1'b1;
    wb_we    = 1'b1;
    wb_adr   = adr;
    wb_dat_w = dat;
    wait_ack(unused);
  endtask

  task automatic bus_read(input logic [7:0] adr, output logic [31:0] data);
    step();
    wb_cyc = 1'b1;
    wb_stb = 1'b1;
    wb_we  = 1'b0;
    wb_adr = adr;
    wait_ack(data);
  endtask

  // random idle cycles after an atom, zero gives back-to-back atoms
  task automatic send_atom(input logic [3:0] flags, input logic [63:0] data);
    int gap;
    step();
    mac_pvld = 1'b1;
    mac_pd   = flags;
    mac_data = data;
    gap = $urandom % 3;
    repeat (gap) step();
  endtask

  task automatic check_word(input string name, input logic [31:0] exp, input logic [31:0] act);
    assert (act == exp) else begin
      mismatch_cnt++;
      $display("mismatch %s expected %08h actual %08h", name, exp, act);
    end
  endtask

  // status only settles once the last expected output has left
  // stepping also takes a held atom off the input after its one cycle
  task automatic drain();
    while (exp_data_q.size() != 0) begin
      step();
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // output monitor
  //////////////////////////////////////////////////////////////////////

  always @(negedge nvdla_core_clk) begin
    string       name;
    logic [63:0] exp_d;
    logic        exp_le;
    if (!reset && out_valid) begin
      if (exp_data_q.size() == 0) begin
        other_cnt++;
        $display("output delivered when none was expected, data %016h", out_data);
      end else begin
        name   = exp_name_q.pop_front();
        exp_d  = exp_data_q.pop_front();
        exp_le = exp_le_q.pop_front();
        assert (out_data == exp_d) else begin
          mismatch_cnt++;
          $display("mismatch %s expected %016h actual %016h", name, exp_d, out_data);
        end
        assert (out_layer_end == exp_le) else begin
          mismatch_cnt++;
          $display("mismatch %s layer end expected %0b actual %0b", name, exp_le,
                   out_layer_end);
        end
      end
    end
  end

  // ack belongs inside a bus cycle and is a single-cycle pulse
  always @(negedge nvdla_core_clk) begin
    if (!reset) begin
      assert (!wb_ack || (wb_cyc && wb_stb)) else begin
        other_cnt++;
        $display("wb_ack was raised outside a bus cycle");
      end
      assert (!(wb_ack && ack_seen)) else begin
        other_cnt++;
        $display("wb_ack stayed high for more than one cycle");
      end
    end
    ack_seen = wb_ack;
  end

  // the run gets 200 cycles for each record of the data file
  initial begin
    wait (nrec != 0);
    repeat (nrec * 200) @(posedge nvdla_core_clk);
    other_cnt++;
    $display("timeout: the run did not finish within %0d cycles", nrec * 200);
    $display("errors: %0d mismatches, %0d other", mismatch_cnt, other_cnt);
    $display("TEST FAILED");
    $finish;
  end

  //////////////////////////////////////////////////////////////////////
  // main sequence
  //////////////////////////////////////////////////////////////////////

  initial begin
    int          fd;
    int          n;
    string       line;
    string       cmd;
    string       name;
    logic [31:0] v0;
    logic [31:0] v1;
    logic [31:0] v2;
    logic [31:0] v3;
    logic [31:0] v4;
    logic [31:0] rd;
    void'($urandom(32'hca2d));
    nvdla_core_clk = 1'b0;
    reset          = 1'b1;
    mac_pvld       = 1'b0;
    mac_pd         = '0;
    mac_data       = '0;
    wb_cyc         = 1'b0;
    wb_stb         = 1'b0;
    wb_we          = 1'b0;
    wb_adr         = '0;
    wb_dat_w       = '0;
    mismatch_cnt   = 0;
    other_cnt      = 0;
    nrec           = 0;
    fd = $fopen("dv/cacc_testdata.txt", "r");
    if (fd == 0) begin
      other_cnt++;
      $display("cannot open the data file dv/cacc_testdata.txt");
    end else begin
      while (!$feof(fd)) begin
        n = $fgets(line, fd);
        if (n > 1 && line[0] != "#") begin
          lines.push_back(line);
        end
      end
      $fclose(fd);
    end
    nrec = lines.size();
    repeat (4) @(posedge nvdla_core_clk);
    #1;
    reset = 1'b0;
    foreach (lines[i]) begin
      v0 = '0;
      v1 = '0;
      v2 = '0;
      v3 = '0;
      v4 = '0;
      n = $sscanf(lines[i], "%s %s %h %h %h %h %h", cmd, name, v0, v1, v2, v3, v4);
      case (cmd)
        "C": bus_write(`CACC_REG_CFG, {23'd0, v1[0], 3'd0, v0[4:0]});
        "S": bus_write(`CACC_REG_OP_EN, 32'd1);
        "A": send_atom(v0[3:0], {v4[15:0], v3[15:0], v2[15:0], v1[15:0]});
        "E": begin
          exp_name_q.push_back(name);
          exp_data_q.push_back({v3[15:0], v2[15:0], v1[15:0], v0[15:0]});
          exp_le_q.push_back(v4[0]);
        end
        "W": begin
          bus_read(v0[7:0], rd);
          check_word(name, v1, rd);
        end
        "R": begin
          drain();
          bus_read(`CACC_REG_STATUS, rd);
          check_word(name, v0, rd);
        end
        default: begin
          other_cnt++;
          $display("unknown command in data file line %0d", i);
        end
      endcase
    end
    drain();
    // a few idle cycles catch stray outputs
    repeat (10) step();
    $display("errors: %0d mismatches, %0d other", mismatch_cnt, other_cnt);
    if (mismatch_cnt == 0 && other_cnt == 0) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

/* dv/cacc_testdata.txt */
# cmd name args in hex: C trunc prec | S | A flags l0 l1 l2 l3 | E l0 l1 l2 l3 layer_end
# W word_addr expected | R expected_status; flags bit0 st, bit1 end, bit2 chan end, bit3 layer end
R t_reset 2
A t_idle 7 0001 0002 0003 0004
C t_single 0 1
S t_single
R t_single 0
A t_single 5 0010 fff0 7fff 8000
E t_single 0010 fff0 7fff 8000 0
A t_single 6 0001 0002 0003 0004
E t_single 0001 0002 0003 0004 0
A t_accum 1 0005 0006 0007 0008
A t_accum 2 0100 0200 0300 0400
W t_win 46 00000300
W t_win 40 00000005
A t_accum 5 0001 0002 0003 0004
E t_accum 0006 0008 000a 000c 0
A t_accum 6 ffff ffff ffff ffff
E t_accum 00ff 01ff 02ff 03ff 0
A t_one 3 0010 0020 0030 0040
A t_one 7 0001 0001 0001 0001
E t_one 0011 0021 0031 0041 0
A t_one f 0002 0003 0004 0005
E t_one 0002 0003 0004 0005 1
R t_done 3
C t_sat 4 0
S t_sat
R t_sat 0
A t_sat 3 7fff 8000 0100 fff0
A t_sat 7 7fff 8000 0010 ffe0
E t_sat 007f ff80 0011 fffd 0
A t_sat f 07f0 f800 0805 ffff
E t_sat 007f ff80 007f ffff 1
R t_sat 3
C t_sat16 0 1
S t_sat16
A t_sat16 3 7fff 8000 4000 c000
A t_sat16 f 7fff 8000 0001 0000
E t_sat16 7fff 8000 4001 c000 1
W t_sat16 40 0000fffe
W t_sat16 41 ffff0000
R t_end 3

/* files.f */
+incdir+design
design/cacc_pkg.sv
design/cacc_abuf_if.sv
design/cacc_assembly_ctrl.sv
design/cacc_assembly_dp.sv
design/cacc_abuf.sv
design/cacc_regs.sv
design/cacc_top.sv
dv/cacc_tb.sv

/* run.sh */
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal -f files.f --top-module cacc_tb -o Vcacc_tb
output="$(./obj_dir/Vcacc_tb)"
echo "$output"

if grep -q "TEST PASSED" <<< "$output"; then
  exit 0
else
  exit 1
fi
